/* pipe_cpu.f */
+incdir+src
+incdir+verif
src/pipe_cpu_pkg.sv
src/insn_fetch.sv
src/insn_decode_regs.sv
src/alu_exec.sv
src/mem_writeback.sv
src/pipe_cpu_top.sv
verif/pipe_cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the pipe_cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module pipe_cpu_tb \
    -f pipe_cpu.f \
    --Mdir "$build_dir" -o pipe_cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/pipe_cpu_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "STATUS: FAIL" "$log_file"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "STATUS: PASS" "$log_file"; then
    echo "No result line found in $log_file"
    exit 1
fi
exit 0

/* src/alu_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_exec (
    input  wire logic             clk,
    input  wire logic             rst,
    input  pipe_cpu_pkg::dec_ex_t dec_i,
    output pipe_cpu_pkg::ex_mem_t ex_o
);
    import pipe_cpu_pkg::*;

    ex_mem_t    ex_q;
    word_t      alu_r;
    logic [3:0] shamt;

    assign ex_o = ex_q;

    // b[1:0] picks 1, 2, 4 or 8
    assign shamt = 4'd1 << dec_i.alu_b[1:0];

    always_comb begin
        case (dec_i.op)
            OP_ADD:  alu_r = dec_i.alu_a + dec_i.alu_b;
            OP_SUB:  alu_r = dec_i.alu_a - dec_i.alu_b;
            OP_OR:   alu_r = dec_i.alu_a | dec_i.alu_b;
            OP_AND:  alu_r = dec_i.alu_a & dec_i.alu_b;
            OP_XOR:  alu_r = dec_i.alu_a ^ dec_i.alu_b;
            OP_NOT:  alu_r = ~dec_i.alu_b;
            OP_SHI: begin
                // b[2] set shifts left
                if (dec_i.alu_b[2]) begin
                    alu_r = dec_i.alu_a << shamt;
                end else begin
                    alu_r = dec_i.alu_a >> shamt;
                end
            end
            default: alu_r = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_q <= '0;
        end else begin
            ex_q.invalid   <= dec_i.invalid;
            ex_q.mem_read  <= dec_i.mem_read;
            ex_q.mem_write <= dec_i.mem_write;
            ex_q.alu_r     <= alu_r;
            ex_q.reg_d     <= dec_i.reg_d;
            ex_q.d_sel     <= dec_i.d_sel;
        end
    end

    op_defined: assert property (
        @(posedge clk) disable iff (rst)
        !dec_i.invalid |-> dec_i.op inside {OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR, OP_NOT, OP_SHI}
    ) else $error("Undefined ALU opcode on a valid item");

endmodule

`default_nettype wire

/* src/insn_decode_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cpu_macros.svh"

module insn_decode_regs (
    input  wire logic              clk,
    input  wire logic              rst,
    input  pipe_cpu_pkg::insn_t    insn_i,
    input  pipe_cpu_pkg::addr_t    insn_addr_i,
    input  pipe_cpu_pkg::ex_mem_t  ex_i,
    input  pipe_cpu_pkg::reg_sel_e mio_d_sel_i,
    input  pipe_cpu_pkg::reg_wr_t  wr_i,
    output logic                   stall_o,
    output pipe_cpu_pkg::dec_ex_t  dec_o
);
    import pipe_cpu_pkg::*;

    word_t    rf [SEL_RA:SEL_SP];
    dec_ex_t  dec_q;
    dec_ex_t  dec_d;
    logic     a_used;
    logic     b_used;
    logic     d_used;
    reg_sel_e dec_dst;
    reg_sel_e ex_dst;
    word_t    imm_ext;
    word_t    pc_ext;

    assign dec_o = dec_q;

    assign imm_ext = {{(`PIPE_CPU_WORD_WIDTH - `PIPE_CPU_IMM_WIDTH){1'b0}}, insn_i.imm};
    assign pc_ext  = {{(`PIPE_CPU_WORD_WIDTH - `PIPE_CPU_ADDR_WIDTH){1'b0}}, insn_addr_i};

    // Write lands at the edge, no bypass into this cycle's read
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            rf[wr_i.d_sel] <= wr_i.value;
        end
    end

    function automatic word_t read_sel(reg_sel_e sel);
        case (sel)
            SEL_R0:  return '0;
            SEL_PC:  return pc_ext;
            default: return rf[sel];
        endcase
    endfunction

    // Destinations still in flight, R0 when nothing is written back
    assign dec_dst = (!dec_q.invalid && !dec_q.mem_write) ? dec_q.d_sel : SEL_R0;
    assign ex_dst  = (!ex_i.invalid && !ex_i.mem_write) ? ex_i.d_sel : SEL_R0;

    assign a_used = (insn_i.op != OP_NOT);
    assign b_used = !insn_i.imm_en;
    // Store data comes from d_sel
    assign d_used = insn_i.mem_write;

    function automatic logic hits(reg_sel_e dst);
        if (dst == SEL_R0 || dst == SEL_PC) begin
            return 1'b0;
        end
        return (a_used && insn_i.a_sel == dst)
            || (b_used && insn_i.b_sel == dst)
            || (d_used && insn_i.d_sel == dst);
    endfunction

    assign stall_o = hits(dec_dst) || hits(ex_dst) || hits(mio_d_sel_i);

    always_comb begin
        dec_d           = '0;
        dec_d.invalid   = 1'b0;
        dec_d.mem_write = insn_i.mem_write;
        dec_d.mem_read  = insn_i.mem_read;
        dec_d.op        = insn_i.op;
        dec_d.alu_a     = read_sel(insn_i.a_sel);
        dec_d.alu_b     = insn_i.imm_en ? imm_ext : read_sel(insn_i.b_sel);
        dec_d.reg_d     = read_sel(insn_i.d_sel);
        dec_d.d_sel     = insn_i.d_sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_q <= '0;
        end else if (stall_o) begin
            // Bubble
            dec_q         <= '0;
            dec_q.invalid <= 1'b1;
        end else begin
            dec_q <= dec_d;
        end
    end

    wr_target_legal: assert property (
        @(posedge clk) disable iff (rst)
        wr_i.en |-> !(wr_i.d_sel inside {SEL_R0, SEL_PC})
    ) else $error("Register write aimed at R0 or PC");

endmodule

`default_nettype wire

/* src/insn_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cpu_macros.svh"

module insn_fetch (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           stall_i,
    input  pipe_cpu_pkg::jump_t                 jump_i,
    input  wire logic [`PIPE_CPU_INSN_WIDTH-1:0] prog_data_i,
    output pipe_cpu_pkg::addr_t                 prog_addr_o,
    output pipe_cpu_pkg::insn_t                 insn_o,
    output pipe_cpu_pkg::addr_t                 insn_addr_o
);
    import pipe_cpu_pkg::*;

    addr_t pc_ff;
    addr_t insn_addr_ff;
    logic  prev_stall_ff;
    insn_t prev_insn_ff;

    assign prog_addr_o = pc_ff;
    assign insn_addr_o = insn_addr_ff;

    // Replay the held word while decode catches up
    assign insn_o = prev_stall_ff ? prev_insn_ff : insn_t'(prog_data_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_ff <= '0;
        end else if (jump_i.en) begin
            pc_ff <= jump_i.addr;
        end else if (!stall_i) begin
            pc_ff <= pc_ff + 1'b1;
        end
    end

    // Set at reset so the first cycle presents a NOP instead of stale bus data
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_stall_ff <= 1'b1;
            prev_insn_ff  <= '0;
        end else begin
            prev_stall_ff <= stall_i;
            prev_insn_ff  <= insn_o;
        end
    end

    // Address of the word now on insn_o
    always_ff @(posedge clk) begin
        if (rst) begin
            insn_addr_ff <= '0;
        end else if (!stall_i) begin
            insn_addr_ff <= pc_ff;
        end
    end

    pc_hold_on_stall: assert property (
        @(posedge clk) disable iff (rst)
        (stall_i && !jump_i.en) |=> $stable(pc_ff)
    ) else $error("PC moved during a stall");

endmodule

`default_nettype wire

/* src/mem_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cpu_macros.svh"

module mem_writeback (
    input  wire logic              clk,
    input  wire logic              rst,
    input  pipe_cpu_pkg::ex_mem_t  ex_i,
    input  pipe_cpu_pkg::word_t    data_i,
    output pipe_cpu_pkg::addr_t    addr_o,
    output pipe_cpu_pkg::word_t    data_o,
    output logic                   we_o,
    output pipe_cpu_pkg::reg_sel_e mio_d_sel_o,
    output pipe_cpu_pkg::reg_wr_t  wr_o,
    output pipe_cpu_pkg::jump_t    jump_o
);
    import pipe_cpu_pkg::*;

    logic     mio_wb_q;
    logic     mio_mem_read_q;
    word_t    mio_alu_r_q;
    reg_sel_e mio_d_sel_q;
    word_t    mio_r;
    jump_t    jump_q;

    assign addr_o = ex_i.alu_r[`PIPE_CPU_ADDR_WIDTH-1:0];
    assign data_o = ex_i.reg_d;
    assign we_o   = ex_i.mem_write && !ex_i.invalid;

    // Stores and bubbles write nothing back
    always_ff @(posedge clk) begin
        if (rst) begin
            mio_wb_q       <= 1'b0;
            mio_mem_read_q <= 1'b0;
            mio_alu_r_q    <= '0;
            mio_d_sel_q    <= SEL_R0;
        end else begin
            mio_wb_q       <= !ex_i.invalid && !ex_i.mem_write;
            mio_mem_read_q <= ex_i.mem_read;
            mio_alu_r_q    <= ex_i.alu_r;
            mio_d_sel_q    <= ex_i.d_sel;
        end
    end

    // Load data arrives one cycle after the address
    assign mio_r = mio_mem_read_q ? data_i : mio_alu_r_q;

    assign mio_d_sel_o = mio_wb_q ? mio_d_sel_q : SEL_R0;

    always_comb begin
        wr_o.en    = mio_wb_q && !(mio_d_sel_q inside {SEL_R0, SEL_PC});
        wr_o.d_sel = mio_d_sel_q;
        wr_o.value = mio_r;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            jump_q <= '0;
        end else begin
            jump_q.en   <= mio_wb_q && (mio_d_sel_q == SEL_PC);
            jump_q.addr <= mio_r[`PIPE_CPU_ADDR_WIDTH-1:0];
        end
    end

    assign jump_o = jump_q;

    no_store_on_load: assert property (
        @(posedge clk) disable iff (rst)
        !(we_o && ex_i.mem_read)
    ) else $error("Store strobe raised for a load");

endmodule

`default_nettype wire

/* src/pipe_cpu_macros.svh */
`ifndef PIPE_CPU_MACROS_SVH
`define PIPE_CPU_MACROS_SVH

// Register and data bus width
`define PIPE_CPU_WORD_WIDTH 32

// Program and data address width
`define PIPE_CPU_ADDR_WIDTH 16

// Instruction word and immediate field
`define PIPE_CPU_INSN_WIDTH 32
`define PIPE_CPU_IMM_WIDTH 16

// Register selector and ALU opcode fields
`define PIPE_CPU_SEL_WIDTH 3
`define PIPE_CPU_OP_WIDTH 3

`endif

/* src/pipe_cpu_pkg.sv */
`default_nettype none

`include "pipe_cpu_macros.svh"

package pipe_cpu_pkg;

    typedef logic [`PIPE_CPU_WORD_WIDTH-1:0] word_t;
    typedef logic [`PIPE_CPU_ADDR_WIDTH-1:0] addr_t;

    typedef enum logic [`PIPE_CPU_SEL_WIDTH-1:0] {
        SEL_R0, SEL_RA, SEL_RB, SEL_RC, SEL_RD, SEL_RE, SEL_SP, SEL_PC
    } reg_sel_e;

    typedef enum logic [`PIPE_CPU_OP_WIDTH-1:0] {
        OP_ADD, OP_SUB, OP_OR, OP_AND, OP_XOR, OP_NOT, OP_SHI
    } alu_op_e;

    // All-zero word is a NOP into R0
    typedef struct packed {
        logic                          spare;
        logic                          mem_write;
        logic                          mem_read;
        reg_sel_e                      d_sel;
        alu_op_e                       op;
        reg_sel_e                      a_sel;
        reg_sel_e                      b_sel;
        logic                          imm_en;
        logic [`PIPE_CPU_IMM_WIDTH-1:0] imm;
    } insn_t;

    typedef struct packed {
        logic     invalid;
        logic     mem_write;
        logic     mem_read;
        alu_op_e  op;
        word_t    alu_a;
        word_t    alu_b;
        word_t    reg_d;
        reg_sel_e d_sel;
    } dec_ex_t;

    typedef struct packed {
        logic     invalid;
        logic     mem_read;
        logic     mem_write;
        word_t    alu_r;
        word_t    reg_d;
        reg_sel_e d_sel;
    } ex_mem_t;

    typedef struct packed {
        logic     en;
        reg_sel_e d_sel;
        word_t    value;
    } reg_wr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } jump_t;

endpackage

`default_nettype wire

/* src/pipe_cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cpu_macros.svh"

module pipe_cpu_top (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [`PIPE_CPU_INSN_WIDTH-1:0] prog_data_i,
    output pipe_cpu_pkg::addr_t                 prog_addr_o,
    input  pipe_cpu_pkg::word_t                 data_i,
    output pipe_cpu_pkg::word_t                 data_o,
    output pipe_cpu_pkg::addr_t                 addr_o,
    output logic                                we_o
);
    import pipe_cpu_pkg::*;

    logic     stall;
    jump_t    jump;
    insn_t    insn;
    addr_t    insn_addr;
    dec_ex_t  dec;
    ex_mem_t  ex;
    reg_sel_e mio_d_sel;
    reg_wr_t  wr;

    insn_fetch i_insn_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall_i     (stall),
        .jump_i      (jump),
        .prog_data_i (prog_data_i),
        .prog_addr_o (prog_addr_o),
        .insn_o      (insn),
        .insn_addr_o (insn_addr)
    );

    insn_decode_regs i_insn_decode_regs (
        .clk         (clk),
        .rst         (rst),
        .insn_i      (insn),
        .insn_addr_i (insn_addr),
        .ex_i        (ex),
        .mio_d_sel_i (mio_d_sel),
        .wr_i        (wr),
        .stall_o     (stall),
        .dec_o       (dec)
    );

    alu_exec i_alu_exec (
        .clk   (clk),
        .rst   (rst),
        .dec_i (dec),
        .ex_o  (ex)
    );

    mem_writeback i_mem_writeback (
        .clk         (clk),
        .rst         (rst),
        .ex_i        (ex),
        .data_i      (data_i),
        .addr_o      (addr_o),
        .data_o      (data_o),
        .we_o        (we_o),
        .mio_d_sel_o (mio_d_sel),
        .wr_o        (wr),
        .jump_o      (jump)
    );

endmodule

`default_nettype wire

/* verif/pipe_cpu_tests.svh */
task automatic alu_op_results();
    word_t   a;
    word_t   b;
    alu_op_e op;
    begin_test();
    a = $random(seed);
    b = $random(seed);
    load_const(SEL_RA, a);
    load_const(SEL_RB, b);
    // One result word per opcode
    for (int k = 0; k <= OP_SHI; k++) begin
        op_regs(alu_op_e'(k), SEL_RC, SEL_RA, SEL_RB);
        store_reg(SEL_RC, SEL_R0, imm_t'(16'h0100 + k));
    end
    end_program();
    run_program("alu_ops");
    for (int k = 0; k <= OP_SHI; k++) begin
        op = alu_op_e'(k);
        check_store($sformatf("alu_ops %s", op.name()), addr_t'(16'h0100 + k),
                    expected_alu(op, a, b));
    end
endtask

task automatic shift_results();
    word_t a;
    begin_test();
    a = $random(seed);
    load_const(SEL_RA, a);
    // Bit 2 is the direction, bits 1:0 the amount
    for (int k = 0; k < 8; k++) begin
        op_imm(OP_SHI, SEL_RD, SEL_RA, imm_t'(k));
        store_reg(SEL_RD, SEL_R0, imm_t'(16'h0200 + k));
    end
    end_program();
    run_program("shifts");
    for (int k = 0; k < 8; k++) begin
        check_store($sformatf("shifts %s by %0d", (k >= 4) ? "left" : "right", 1 << (k % 4)),
                    addr_t'(16'h0200 + k), expected_alu(OP_SHI, a, word_t'(k)));
    end
endtask

task automatic hazard_chain();
    word_t ra;
    word_t rb;
    word_t rc;
    word_t rd;
    word_t re;
    word_t sp;
    begin_test();
    ra = $random(seed);
    load_const(SEL_RA, ra);
    op_imm(OP_ADD, SEL_RB, SEL_RA, 16'h1234);
    rb = expected_alu(OP_ADD, ra, 32'h1234);
    op_regs(OP_SUB, SEL_RC, SEL_RB, SEL_RA);
    rc = expected_alu(OP_SUB, rb, ra);
    op_regs(OP_XOR, SEL_RD, SEL_RC, SEL_RB);
    rd = expected_alu(OP_XOR, rc, rb);
    store_reg(SEL_RD, SEL_R0, 16'h0300);
    op_regs(OP_ADD, SEL_RE, SEL_RD, SEL_RD);
    re = expected_alu(OP_ADD, rd, rd);
    op_imm(OP_SHI, SEL_SP, SEL_RE, 16'h0004);
    sp = expected_alu(OP_SHI, re, 32'h4);
    // Fresh base register and fresh store data together
    op_imm(OP_ADD, SEL_RA, SEL_R0, 16'h0310);
    store_reg(SEL_SP, SEL_RA, 16'h0001);
    op_regs(OP_ADD, SEL_RB, SEL_RB, SEL_RB);
    store_reg(SEL_RB, SEL_R0, 16'h0302);
    store_reg(SEL_RE, SEL_R0, 16'h0303);
    end_program();
    run_program("hazards");
    check_store("hazards xor store", 16'h0300, rd);
    check_store("hazards based store", 16'h0311, sp);
    check_store("hazards self add", 16'h0302, expected_alu(OP_ADD, rb, rb));
    check_store("hazards late store", 16'h0303, re);
endtask

task automatic load_add_store();
    word_t w0;
    word_t w1;
    begin_test();
    w0 = $random(seed);
    w1 = $random(seed);
    data_mem[16'h0400] = w0;
    data_mem[16'h0401] = w1;
    op_imm(OP_ADD, SEL_RA, SEL_R0, 16'h0400);
    load_mem(SEL_RB, SEL_RA, 16'h0000);
    load_mem(SEL_RC, SEL_RA, 16'h0001);
    op_regs(OP_ADD, SEL_RD, SEL_RB, SEL_RC);
    store_reg(SEL_RD, SEL_RA, 16'h0010);
    load_mem(SEL_RE, SEL_R0, 16'h0500);
    store_reg(SEL_RE, SEL_R0, 16'h0411);
    end_program();
    run_program("loads");
    if (wr_log.size() != 2) begin
        $display("loads: expected two stores before done but saw %0d", wr_log.size());
        fail_run();
    end else begin
        compare_addr("loads sum address", 16'h0410, wr_log[0].addr);
        compare_word("loads sum value", expected_alu(OP_ADD, w0, w1), wr_log[0].data);
        compare_addr("loads fill address", 16'h0411, wr_log[1].addr);
        compare_word("loads fill value", fill_word(16'h0500), wr_log[1].data);
    end
endtask

task automatic jump_and_selectors();
    word_t mark;
    word_t skipped;
    int    pc_store;
    int    jump_at;
    int    target;
    begin_test();
    mark = $random(seed);
    load_const(SEL_RA, mark);
    store_reg(SEL_R0, SEL_R0, 16'h0500);
    pc_store = prog_len;
    store_reg(SEL_PC, SEL_R0, 16'h0501);
    jump_at = prog_len;
    target  = jump_at + 12;
    op_imm(OP_ADD, SEL_PC, SEL_R0, imm_t'(target));
    // Eight NOP words already sit between the jump and the marker
    prog_len = jump_at + 9;
    store_reg(SEL_RA, SEL_R0, 16'h0502);
    prog_len = target;
    store_reg(SEL_RA, SEL_R0, 16'h0503);
    end_program();
    run_program("jumps");
    check_store("jumps R0 operand", 16'h0500, '0);
    check_store("jumps PC operand", 16'h0501, word_t'(pc_store));
    if (find_write(16'h0502, skipped)) begin
        $display("jumps: the marker store behind the jump was executed");
        fail_run();
    end else begin
        check_store("jumps target marker", 16'h0503, mark);
    end
endtask

/* verif/pipe_cpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "pipe_cpu_macros.svh"

module pipe_cpu_tb;
    import pipe_cpu_pkg::*;

    typedef logic [`PIPE_CPU_IMM_WIDTH-1:0] imm_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
    } mem_wr_t;

    localparam addr_t DONE_ADDR    = 16'hFFFF;
    localparam int    DONE_TIMEOUT = 2000;
    localparam int    MEM_WORDS    = 1 << `PIPE_CPU_ADDR_WIDTH;

    logic                            clk;
    logic                            rst;
    logic [`PIPE_CPU_INSN_WIDTH-1:0] prog_data_i;
    addr_t                           prog_addr_o;
    word_t                           data_i;
    word_t                           data_o;
    addr_t                           addr_o;
    logic                            we_o;

    insn_t   prog_mem [0:MEM_WORDS-1];
    word_t   data_mem [0:MEM_WORDS-1];
    addr_t   prog_addr_q;
    addr_t   data_addr_q;
    mem_wr_t wr_rec;
    mem_wr_t wr_log [$];
    logic    done_seen;
    int      prog_len;
    int      seed;

    pipe_cpu_top i_pipe_cpu_top (
        .clk         (clk),
        .rst         (rst),
        .prog_data_i (prog_data_i),
        .prog_addr_o (prog_addr_o),
        .data_i      (data_i),
        .data_o      (data_o),
        .addr_o      (addr_o),
        .we_o        (we_o)
    );

    always #10 clk = ~clk;

    // Both memories answer one cycle after the address
    always @(negedge clk) begin
        prog_data_i = prog_mem[prog_addr_q];
        prog_addr_q = prog_addr_o;
        data_i      = data_mem[data_addr_q];
        data_addr_q = addr_o;
        if (we_o) begin
            data_mem[addr_o] = data_o;
            wr_rec.addr      = addr_o;
            wr_rec.data      = data_o;
            if (addr_o == DONE_ADDR) begin
                done_seen = 1'b1;
            end else begin
                wr_log.push_back(wr_rec);
            end
        end
    end

    function automatic word_t fill_word(addr_t a);
        return {~a, a ^ 16'h3C3C};
    endfunction

    function automatic insn_t build_insn(logic wr, logic rd, reg_sel_e d, alu_op_e op,
                                         reg_sel_e a, reg_sel_e b, logic imm_en, imm_t imm);
        insn_t w;
        w           = '0;
        w.mem_write = wr;
        w.mem_read  = rd;
        w.d_sel     = d;
        w.op        = op;
        w.a_sel     = a;
        w.b_sel     = b;
        w.imm_en    = imm_en;
        w.imm       = imm;
        return w;
    endfunction

    task automatic append_insn(insn_t insn);
        prog_mem[prog_len] = insn;
        prog_len++;
    endtask

    task automatic op_regs(alu_op_e op, reg_sel_e d, reg_sel_e a, reg_sel_e b);
        append_insn(build_insn(1'b0, 1'b0, d, op, a, b, 1'b0, '0));
    endtask

    task automatic op_imm(alu_op_e op, reg_sel_e d, reg_sel_e a, imm_t imm);
        append_insn(build_insn(1'b0, 1'b0, d, op, a, SEL_R0, 1'b1, imm));
    endtask

    task automatic store_reg(reg_sel_e data_sel, reg_sel_e base, imm_t offset);
        append_insn(build_insn(1'b1, 1'b0, data_sel, OP_ADD, base, SEL_R0, 1'b1, offset));
    endtask

    task automatic load_mem(reg_sel_e d, reg_sel_e base, imm_t offset);
        append_insn(build_insn(1'b0, 1'b1, d, OP_ADD, base, SEL_R0, 1'b1, offset));
    endtask

    // High half, two left shifts by 8, then the low half
    task automatic load_const(reg_sel_e d, word_t value);
        op_imm(OP_ADD, d, SEL_R0, value[31:16]);
        op_imm(OP_SHI, d, d, 16'h0007);
        op_imm(OP_SHI, d, d, 16'h0007);
        op_imm(OP_OR, d, d, value[15:0]);
    endtask

    task automatic end_program();
        store_reg(SEL_R0, SEL_R0, DONE_ADDR);
    endtask

    function automatic word_t expected_alu(alu_op_e op, word_t a, word_t b);
        int amount;
        amount = 1 << b[1:0];
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a + (~b) + 32'd1;
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_NOT:  return b ^ 32'hFFFF_FFFF;
            OP_SHI:  return b[2] ? (a << amount) : (a >> amount);
            default: return '0;
        endcase
    endfunction

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_word(string test_name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", test_name, expected, actual);
            fail_run();
        end
    endtask

    task automatic compare_addr(string test_name, addr_t expected, addr_t actual);
        if (actual !== expected) begin
            $display("Error: %s expected %h actual %h", test_name, expected, actual);
            fail_run();
        end
    endtask

    function automatic bit find_write(addr_t addr, output word_t data);
        data = '0;
        foreach (wr_log[i]) begin
            if (wr_log[i].addr == addr) begin
                data = wr_log[i].data;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_store(string test_name, addr_t addr, word_t expected);
        word_t actual;
        if (!find_write(addr, actual)) begin
            $display("%s: the program never stored to address %h", test_name, addr);
            fail_run();
        end else begin
            compare_word(test_name, expected, actual);
        end
    endtask

    // Reset stays high while the memories are loaded
    task automatic begin_test();
        @(negedge clk);
        rst = 1'b1;
        @(posedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            prog_mem[i] = '0;
            data_mem[i] = fill_word(addr_t'(i));
        end
        wr_log.delete();
        done_seen = 1'b0;
        prog_len  = 0;
    endtask

    task automatic run_program(string test_name);
        int cycles;
        repeat (10) @(negedge clk);
        rst    = 1'b0;
        cycles = 0;
        while (!done_seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            $display("%s: the program never finished, no done store in %0d cycles",
                     test_name, DONE_TIMEOUT);
            fail_run();
        end
    endtask

    `include "pipe_cpu_tests.svh"

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        prog_data_i = '0;
        data_i      = '0;
        prog_addr_q = '0;
        data_addr_q = '0;
        done_seen   = 1'b0;
        prog_len    = 0;
        seed        = 32'h6193;
        alu_op_results();
        shift_results();
        hazard_chain();
        load_add_store();
        jump_and_selectors();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire
